//--- filelist.f
+incdir+design
design/kbd_pkg.sv
design/game_pkg.sv
design/scan_decode.sv
design/goal_gen.sv
design/guess_fsm.sv
design/seg_scan.sv
design/guess_top.sv
testbench/tb_guess.sv

//--- testbench/tb_guess.sv
`default_nettype none

`include "guess_params.svh"

module tb_guess;
    timeunit 1ns;
    timeprecision 100ps;

    import kbd_pkg::*;
    import game_pkg::*;

    localparam int scan_wait = 64;    // cycles per anode wait
    localparam int hold_wait = 200;   // cycles for the win hold to end

    localparam logic [7:0] main_code [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };
    localparam logic [7:0] pad_code [10] = '{
        8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
    };

    logic        clk;
    logic        rst;
    key_event_t  key_evt;
    logic        start;
    logic        cheat;
    logic [6:0]  seg;
    logic [3:0]  an;
    logic [15:0] led;

    integer      seed;
    int unsigned cyc;
    bcd2_t       goal;
    bounds_t     bnd;
    bcd2_t       entry;
    disp_word_t  shown;

    guess_top #(.scan_div_bits(2), .win_hold(50)) uut (
        .clk     (clk),
        .rst     (rst),
        .key_evt (key_evt),
        .start   (start),
        .cheat   (cheat),
        .seg     (seg),
        .an      (an),
        .led     (led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // LFSR steps since reset release
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] lfsr_step(logic [7:0] l);
        return {l[6:0], l[6] ^ l[0]};
    endfunction

    function automatic bcd2_t goal_of(logic [7:0] l);
        int    v;
        bcd2_t g;
        v      = int'(l[6:0]) % `GOAL_MOD + 1;
        g.tens = 4'(v / 10);
        g.ones = 4'(v % 10);
        return g;
    endfunction

    function automatic bounds_t apply_guess(bounds_t b, bcd2_t g, bcd2_t target);
        bounds_t r;
        r = b;
        if (g > b.lo && g < b.hi) begin
            if (g > target) begin
                r.hi = g;
            end else if (g < target) begin
                r.lo = g;
            end else begin
                r.lo = g;   // range closes on a hit
                r.hi = g;
            end
        end
        return r;
    endfunction

    // active low, g..a
    function automatic logic [6:0] seg_of(logic [3:0] n);
        case (n)
            4'h0:      return 7'b1000000;
            4'h1:      return 7'b1111001;
            4'h2:      return 7'b0100100;
            4'h3:      return 7'b0110000;
            4'h4:      return 7'b0011001;
            4'h5:      return 7'b0010010;
            4'h6:      return 7'b0000010;
            4'h7:      return 7'b1111000;
            4'h8:      return 7'b0000000;
            4'h9:      return 7'b0010000;
            `NIB_DASH: return 7'b0111111;
            default:   return 7'b1111111;
        endcase
    endfunction

    function automatic logic [3:0] nib_of(logic [6:0] s);
        logic [3:0] r;
        r = 4'hF;   // no match
        for (int k = 11; k >= 0; k--) begin
            if (seg_of(4'(k)) == s) begin
                r = 4'(k);
            end
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and display readback
    //////////////////////////////////////////////////////////////////////

    task automatic abort_test(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_disp(string name, disp_word_t exp, disp_word_t act);
        if (exp !== act) begin
            abort_test($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_led(string name, logic [15:0] exp, logic [15:0] act);
        if (exp !== act) begin
            abort_test($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic read_display(output disp_word_t d);
        int n;
        for (int i = 0; i < `NUM_DIGITS; i++) begin
            n = 0;
            @(negedge clk);
            while (an !== ~(4'b0001 << i)) begin
                if (n == scan_wait) begin
                    abort_test($sformatf("anode of digit %0d was never selected", i));
                end
                n++;
                @(negedge clk);
            end
            d[i] = nib_of(seg);
        end
    endtask

    task automatic expect_disp(string name, disp_word_t exp);
        read_display(shown);
        check_disp(name, exp, shown);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic press_key(logic [7:0] code, logic ext, logic brk);
        @(posedge clk);
        key_evt <= {1'b1, ext, brk, code};
        @(posedge clk);
        key_evt <= '0;
        repeat (4) @(posedge clk);   // decode, state and display latency
    endtask

    task automatic type_digit(logic [3:0] d);
        if (1'($random(seed))) begin
            press_key(pad_code[d], 1'b0, 1'b0);
        end else begin
            press_key(main_code[d], 1'b0, 1'b0);
        end
        entry = {entry.ones, d};
    endtask

    task automatic press_enter();
        press_key(8'h5A, 1'($random(seed)), 1'b0);   // main or keypad enter
    endtask

    task automatic enter_guess(bcd2_t g);
        entry = '0;
        type_digit(g.tens);
        type_digit(g.ones);
        press_enter();
        bnd = apply_guess(bnd, g, goal);
    endtask

    task automatic start_game();
        logic [7:0] l;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        l = `LFSR_SEED;
        repeat (cyc) l = lfsr_step(l);   // value the DUT latches at this edge
        goal  = goal_of(l);
        start <= 1'b0;
        bnd   = {`BOUND_LO_INIT, `BOUND_HI_INIT};
        repeat (4) @(posedge clk);
    endtask

    task automatic show_goal(string name);
        @(posedge clk);
        cheat <= 1'b1;
        repeat (3) @(posedge clk);
        expect_disp(name, {goal, `NIB_BLANK, `NIB_BLANK});
        @(posedge clk);
        cheat <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    function automatic bcd2_t random_guess();
        bcd2_t g;
        g.tens = 4'($unsigned($random(seed)) % 10);
        g.ones = 4'($unsigned($random(seed)) % 10);
        if (g == goal) begin
            g = bnd.lo;   // keeps the game open
        end
        return g;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int n;
        seed    = 32'h37c0_6f9b;
        rst     = 1'b1;
        key_evt = '0;
        start   = 1'b0;
        cheat   = 1'b0;
        entry   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        expect_disp("reset display", {`NUM_DIGITS{`NIB_DASH}});
        @(negedge clk);
        check_led("reset led", '0, led);

        start_game();
        expect_disp("start range", {bnd.lo, bnd.hi});
        show_goal("cheat goal");

        entry = '0;
        for (int i = 0; i < 8; i++) begin
            type_digit(4'($unsigned($random(seed)) % 10));
            expect_disp("typed digits", {`NIB_BLANK, `NIB_BLANK, entry});
        end
        press_key(main_code[3], 1'b0, 1'b1);
        expect_disp("break event", {`NIB_BLANK, `NIB_BLANK, entry});
        press_key(8'h1C, 1'b0, 1'b0);   // letter key
        expect_disp("unmapped code", {`NIB_BLANK, `NIB_BLANK, entry});

        for (int i = 0; i < 12; i++) begin
            enter_guess(random_guess());
            expect_disp("guess bounds", {bnd.lo, bnd.hi});
        end

        enter_guess(goal);
        @(negedge clk);
        check_led("win led", '1, led);
        expect_disp("win display", {goal, goal});
        n = 0;
        @(negedge clk);
        while (led !== '0) begin
            if (n == hold_wait) begin
                abort_test("led stayed on after the win hold");
            end
            n++;
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        expect_disp("idle after win", {`NUM_DIGITS{`NIB_DASH}});

        start_game();
        expect_disp("second start", {bnd.lo, bnd.hi});
        press_enter();
        expect_disp("enter in range", {bnd.lo, bnd.hi});
        show_goal("second goal");
        enter_guess(random_guess());
        expect_disp("second guess", {bnd.lo, bnd.hi});

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/guess_top.sv
`default_nettype none

`include "guess_params.svh"

module guess_top #(
    parameter int scan_div_bits = `SCAN_DIV_BITS_DEF,
    parameter int win_hold      = `WIN_HOLD_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::key_event_t key_evt,
    input  logic                start,
    input  logic                cheat,
    output logic [6:0]          seg,
    output logic [3:0]          an,
    output logic [15:0]         led
);
    import kbd_pkg::*;
    import game_pkg::*;

    key_sym_t   key_sym;
    bcd2_t      goal_cand;
    disp_word_t disp;

    scan_decode u_scan_decode (
        .clk     (clk),
        .rst     (rst),
        .key_evt (key_evt),
        .key_sym (key_sym)
    );

    goal_gen u_goal_gen (
        .clk       (clk),
        .rst       (rst),
        .goal_cand (goal_cand)
    );

    guess_fsm #(.win_hold(win_hold)) u_guess_fsm (
        .clk       (clk),
        .rst       (rst),
        .key_sym   (key_sym),
        .start     (start),
        .cheat     (cheat),
        .goal_cand (goal_cand),
        .disp      (disp),
        .led       (led)
    );

    seg_scan #(.scan_div_bits(scan_div_bits)) u_seg_scan (
        .clk  (clk),
        .rst  (rst),
        .disp (disp),
        .seg  (seg),
        .an   (an)
    );

endmodule

`default_nettype wire

//--- design/seg_scan.sv
`default_nettype none

`include "guess_params.svh"

module seg_scan #(
    parameter int scan_div_bits = `SCAN_DIV_BITS_DEF
) (
    input  logic                     clk,
    input  logic                     rst,
    input  game_pkg::disp_word_t     disp,
    output logic [6:0]               seg,
    output logic [`NUM_DIGITS-1:0]   an
);

    localparam int idx_w = $clog2(`NUM_DIGITS);

    logic [scan_div_bits-1:0] div_cnt;
    logic [idx_w-1:0]         idx;
    logic [`BCD_W-1:0]        nib;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            idx     <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (&div_cnt) begin
                idx <= idx + 1'b1;  // next digit
            end
        end
    end

    assign an  = ~(`NUM_DIGITS'(1) << idx);
    assign nib = disp[idx];

    // active low, seg[6:0] = g..a
    always_comb begin
        case (nib)
            4'h0:      seg = 7'b1000000;
            4'h1:      seg = 7'b1111001;
            4'h2:      seg = 7'b0100100;
            4'h3:      seg = 7'b0110000;
            4'h4:      seg = 7'b0011001;
            4'h5:      seg = 7'b0010010;
            4'h6:      seg = 7'b0000010;
            4'h7:      seg = 7'b1111000;
            4'h8:      seg = 7'b0000000;
            4'h9:      seg = 7'b0010000;
            `NIB_DASH: seg = 7'b0111111;
            default:   seg = 7'b1111111;  // blank and unused codes
        endcase
    end

endmodule

`default_nettype wire

//--- design/guess_fsm.sv
`default_nettype none

`include "guess_params.svh"

module guess_fsm #(
    parameter int win_hold = `WIN_HOLD_DEF
) (
    input  logic                 clk,
    input  logic                 rst,
    input  kbd_pkg::key_sym_t    key_sym,
    input  logic                 start,
    input  logic                 cheat,
    input  game_pkg::bcd2_t      goal_cand,
    output game_pkg::disp_word_t disp,
    output logic [15:0]          led
);
    import kbd_pkg::*;
    import game_pkg::*;

    localparam int cnt_w = $clog2(win_hold + 1);

    game_state_e      state;
    bcd2_t            goal;
    bcd2_t            entry;
    bounds_t          bnd;
    bounds_t          bnd_chk;
    logic [cnt_w-1:0] win_cnt;
    logic             key_digit;
    logic             key_enter;
    logic             won;
    logic             in_range;
    disp_word_t       disp_nxt;

    assign key_digit = key_sym.strobe && key_sym.kind == KEY_DIGIT;
    assign key_enter = key_sym.strobe && key_sym.kind == KEY_ENTER;
    assign won       = bnd.lo == bnd.hi;
    assign in_range  = entry > bnd.lo && entry < bnd.hi;

    //////////////////////////////////////////////////////////////////////
    // bound update for the guess in entry
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        bnd_chk = bnd;
        if (in_range) begin
            if (entry > goal) begin
                bnd_chk.hi = entry;
            end else if (entry < goal) begin
                bnd_chk.lo = entry;
            end else begin
                bnd_chk.lo = entry;  // hit, range closes
                bnd_chk.hi = entry;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state, bounds, win hold
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= GS_IDLE;
            bnd     <= {`BOUND_LO_INIT, `BOUND_HI_INIT};
            win_cnt <= '0;
            led     <= '0;
        end else begin
            case (state)
                GS_IDLE: begin
                    if (start) begin
                        state  <= GS_RANGE;
                        bnd.lo <= `BOUND_LO_INIT;
                        bnd.hi <= `BOUND_HI_INIT;
                    end
                end
                GS_RANGE: begin
                    if (won) begin
                        if (win_cnt == cnt_w'(win_hold)) begin
                            state   <= GS_IDLE;
                            win_cnt <= '0;
                            led     <= '0;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                            led     <= '1;
                        end
                    end else if (key_digit) begin
                        state <= GS_ENTRY;
                    end
                end
                GS_ENTRY: begin
                    if (key_enter) begin
                        state <= GS_CHECK;
                    end
                end
                GS_CHECK: begin
                    bnd   <= bnd_chk;
                    state <= GS_RANGE;
                end
                default: begin
                    state <= GS_IDLE;
                end
            endcase
        end
    end

    // goal and typed digits
    always_ff @(posedge clk) begin
        if (state == GS_IDLE && start) begin
            goal <= goal_cand;
        end
        if (key_digit && state == GS_RANGE && !won) begin
            entry <= {{`BCD_W{1'b0}}, key_sym.digit};  // first digit
        end else if (key_digit && state == GS_ENTRY) begin
            entry <= {entry.ones, key_sym.digit};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // display word
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            GS_IDLE:  disp_nxt = {`NUM_DIGITS{`NIB_DASH}};
            GS_RANGE: disp_nxt = bnd;
            default:  disp_nxt = {`NIB_BLANK, `NIB_BLANK, entry};  // entry and check
        endcase
        if (cheat && state != GS_IDLE) begin
            disp_nxt = {goal, `NIB_BLANK, `NIB_BLANK};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            disp <= {`NUM_DIGITS{`NIB_DASH}};
        end else begin
            disp <= disp_nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/goal_gen.sv
`default_nettype none

`include "guess_params.svh"

module goal_gen (
    input  logic            clk,
    input  logic            rst,
    output game_pkg::bcd2_t goal_cand
);

    logic [`LFSR_W-1:0] lfsr;
    logic               fb;
    logic [6:0]         red;
    logic [6:0]         val;
    logic [`BCD_W-1:0]  tens;
    logic [6:0]         rem;

    assign fb = lfsr[`LFSR_TAP_A] ^ lfsr[`LFSR_TAP_B];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `LFSR_SEED;
        end else begin
            lfsr <= {lfsr[`LFSR_W-2:0], fb};  // runs through every game
        end
    end

    // 0..127 folded once gives 0..96, then 1..97
    always_comb begin
        red  = (lfsr[6:0] >= 7'(`GOAL_MOD)) ? lfsr[6:0] - 7'(`GOAL_MOD) : lfsr[6:0];
        val  = red + 7'd1;
        tens = '0;
        for (int t = 1; t < 10; t++) begin
            if (val >= 7'(t * 10)) begin
                tens = t[`BCD_W-1:0];
            end
        end
        rem = val - 7'(tens) * 7'd10;
    end

    assign goal_cand = {tens, rem[`BCD_W-1:0]};

endmodule

`default_nettype wire

//--- design/scan_decode.sv
`default_nettype none

`include "guess_params.svh"

module scan_decode (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::key_event_t key_evt,
    output kbd_pkg::key_sym_t   key_sym
);
    import kbd_pkg::*;

    // set 2 make codes, index is the digit value
    localparam logic [7:0] main_codes [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };
    localparam logic [7:0] pad_codes [10] = '{
        8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
    };
    localparam logic [7:0] enter_code = 8'h5A;

    key_kind_e         kind;
    logic [`BCD_W-1:0] digit;

    always_comb begin
        kind  = KEY_NONE;
        digit = '0;
        if (key_evt.code == enter_code) begin
            kind = KEY_ENTER;  // main and keypad enter
        end else if (!key_evt.extended) begin
            for (int i = 0; i < 10; i++) begin
                if (key_evt.code == main_codes[i] || key_evt.code == pad_codes[i]) begin
                    kind  = KEY_DIGIT;
                    digit = i[`BCD_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_sym <= '0;
        end else begin
            key_sym.strobe <= key_evt.strobe && !key_evt.brk && kind != KEY_NONE;
            key_sym.kind   <= kind;
            key_sym.digit  <= digit;
        end
    end

endmodule

`default_nettype wire

//--- design/game_pkg.sv
`default_nettype none

`include "guess_params.svh"

package game_pkg;

    typedef enum logic [1:0] {
        GS_IDLE,
        GS_RANGE,
        GS_ENTRY,
        GS_CHECK
    } game_state_e;

    // two BCD digits, compares like a binary byte
    typedef struct packed {
        logic [`BCD_W-1:0] tens;
        logic [`BCD_W-1:0] ones;
    } bcd2_t;

    typedef struct packed {
        bcd2_t lo;  // shown on the left
        bcd2_t hi;
    } bounds_t;

    // index 3 is the leftmost digit
    typedef logic [`NUM_DIGITS-1:0][`BCD_W-1:0] disp_word_t;

endpackage

`default_nettype wire

//--- design/kbd_pkg.sv
`default_nettype none

`include "guess_params.svh"

package kbd_pkg;

    // framed keyboard event, one strobe per scan code
    typedef struct packed {
        logic       strobe;
        logic       extended;   // E0 prefix seen
        logic       brk;        // F0 prefix seen
        logic [7:0] code;
    } key_event_t;

    typedef enum logic [1:0] {
        KEY_NONE,
        KEY_DIGIT,
        KEY_ENTER
    } key_kind_e;

    typedef struct packed {
        logic                strobe;
        key_kind_e           kind;
        logic [`BCD_W-1:0]   digit;
    } key_sym_t;

endpackage

`default_nettype wire

//--- design/guess_params.svh
`ifndef GUESS_PARAMS_SVH
`define GUESS_PARAMS_SVH

// display nibbles
`define BCD_W               4
`define NUM_DIGITS          4
`define NIB_DASH            4'hA    // middle bar only
`define NIB_BLANK           4'hB    // all segments off

// goal generator
`define LFSR_W              8
`define LFSR_SEED           8'h01
`define LFSR_TAP_A          6
`define LFSR_TAP_B          0
`define GOAL_MOD            97

// game bounds, BCD
`define BOUND_LO_INIT       8'h00
`define BOUND_HI_INIT       8'h99

// timing defaults
`define SCAN_DIV_BITS_DEF   13
`define WIN_HOLD_DEF        (1 << 24)

`endif
